// ==== src/mmu_settings.svh ====
/*
 * Sv39 walker settings
 * Field widths, table depth and MMU cache size shared by all blocks
 */

`ifndef MMU_SETTINGS_SVH
`define MMU_SETTINGS_SVH

// Sv39 has three table levels
`define PT_LEVELS 3

// One VPN part indexes 512 entries
`define VPN_PART_LEN 9

// Physical page number and address
`define PPN_LEN 44
`define PAGE_OFFSET_LEN 12
`define PADDR_LEN 56

// Page table entry
`define PTE_LEN 64

// Entries per MMU cache side
`define MMUC_ENTRIES 4

`endif

// ==== src/mmu_types_pkg.sv ====
/*
 * Sv39 address format types
 * Virtual page number, page table entry and walk result encodings
 */

`include "mmu_settings.svh"

package mmu_types_pkg;

  // VPN split in one part per level, part 2 on top
  typedef logic [`PT_LEVELS-1:0][`VPN_PART_LEN-1:0] vpn_t;

  // Sv39 PTE, flags in the low byte
  typedef struct packed {
    logic [`PTE_LEN-`PPN_LEN-11:0] reserved;
    logic [`PPN_LEN-1:0]           ppn;
    logic [1:0]                    rsw;
    logic                          d;
    logic                          a;
    logic                          g;
    logic                          u;
    logic                          x;
    logic                          w;
    logic                          r;
    logic                          v;
  } pte_t;

  // Level value doubles as the VPN part index
  typedef enum logic [1:0] {
    Lvl0 = 2'd0,
    Lvl1 = 2'd1,
    Lvl2 = 2'd2
  } pte_level_e;

  typedef enum logic [1:0] {
    KibiPage,
    MebiPage,
    GibiPage
  } page_type_e;

  typedef enum logic [1:0] {
    NoException,
    PageFault,
    AccessFault
  } exception_e;

  // Access permissions of a leaf
  typedef struct packed {
    logic w;
    logic r;
    logic x;
  } wrx_t;

endpackage

// ==== src/mmu_bus_pkg.sv ====
/*
 * MMU channel structs
 * Payloads of the TLB, memory and MMU cache ports
 */

`include "mmu_settings.svh"

package mmu_bus_pkg;

  import mmu_types_pkg::*;

  // Translation request from the TLB
  typedef struct packed {
    logic valid;
    vpn_t vpn;
  } tlb_req_t;

  // Walk result, valid stays on top
  typedef struct packed {
    logic                valid;
    logic [`PPN_LEN-1:0] ppn;
    page_type_e          page_type;
    exception_e          exception;
    wrx_t                wrx;
    logic                d;
    logic                g;
    logic                u;
  } tlb_ans_t;

  // PTE read towards memory
  typedef struct packed {
    logic                  valid;
    logic [`PADDR_LEN-1:0] pte_paddr;
  } mem_req_t;

  typedef struct packed {
    logic valid;
    pte_t pte;
    logic err;
  } mem_ans_t;

  // Cache answer, full_hit implies hit
  typedef struct packed {
    logic                hit;
    logic                full_hit;
    logic [`PPN_LEN-1:0] ppn;
  } mmuc_lookup_t;

  // Cache fill, partial entries keep their tag in the upper part
  typedef struct packed {
    logic                       wr_en;
    logic                       full;
    logic [2*`VPN_PART_LEN-1:0] tag;
    logic [`PPN_LEN-1:0]        ppn;
  } mmuc_write_t;

endpackage

// ==== src/stream_reg.sv ====
/*
 * One-entry valid/ready slice
 * Payload type is a parameter, flush drops the held entry
 */

module stream_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     flush_i,
  input  logic     valid_i,
  output logic     ready_o,
  input  payload_t data_i,
  output logic     valid_o,
  input  logic     ready_i,
  output payload_t data_o
);

  logic     valid_q;
  payload_t data_q;

  // Free when empty or drained in this cycle
  assign ready_o = !valid_q || ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      data_q <= data_i;
    end
  end

  assign valid_o = valid_q;
  assign data_o  = data_q;

endmodule

// ==== src/pte_checker.sv ====
/*
 * PTE checker
 * Classifies a fetched entry as pointer, leaf or fault at its level
 */

`include "mmu_settings.svh"

module pte_checker (
  input  mmu_types_pkg::pte_level_e level_i,
  input  mmu_types_pkg::pte_t       pte_i,
  input  logic                      mem_err_i,
  output mmu_types_pkg::exception_e exception_o,
  output logic                      leaf_o,
  output logic                      done_o
);

  import mmu_types_pkg::*;

  // Readable or executable means leaf
  assign leaf_o = pte_i.r || pte_i.x;

  always_comb begin
    exception_o = NoException;
    if (mem_err_i) begin
      exception_o = AccessFault;
    end else if (!pte_i.v || (pte_i.w && !pte_i.r)) begin
      exception_o = PageFault;
    end else if (leaf_o) begin
      // Leaf must be accessed and superpages aligned
      if (!pte_i.a) begin
        exception_o = PageFault;
      end else if (level_i == Lvl2 && |pte_i.ppn[2*`VPN_PART_LEN-1:0]) begin
        exception_o = PageFault;
      end else if (level_i == Lvl1 && |pte_i.ppn[`VPN_PART_LEN-1:0]) begin
        exception_o = PageFault;
      end
    end else if (level_i == Lvl0) begin
      // No table below the last level
      exception_o = PageFault;
    end
  end

  assign done_o = leaf_o || (exception_o != NoException);

endmodule

// ==== src/ptw_cu.sv ====
/*
 * Walker control unit
 * FSM sequencing lookup, memory reads, checks and the answer,
 * holding the request slice until the answer slice empties
 */

module ptw_cu (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic flush_i,
  input  logic req_valid_i,
  input  logic mem_req_rdy_i,
  input  logic mem_ans_valid_i,
  input  logic done_i,
  input  logic ans_rdy_i,
  output logic req_rdy_o,
  output logic load_level_o,
  output logic issue_o,
  output logic mem_req_valid_o,
  output logic mem_ans_rdy_o,
  output logic step_o,
  output logic finish_o
);

  typedef enum logic [2:0] {
    Idle,
    Lookup,
    Send,
    Wait,
    Check,
    Answer
  } state_e;

  state_e state_q, state_d;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      Idle: begin
        if (req_valid_i) begin
          state_d = Lookup;
        end
      end
      Lookup: state_d = Send;
      Send: begin
        if (mem_req_rdy_i) begin
          state_d = Wait;
        end
      end
      Wait: begin
        if (mem_ans_valid_i) begin
          state_d = Check;
        end
      end
      Check: begin
        // Pointer goes one level down, otherwise hand over the answer
        if (!done_i) begin
          state_d = Send;
        end else if (ans_rdy_i) begin
          state_d = Answer;
        end
      end
      Answer: begin
        if (ans_rdy_i) begin
          state_d = Idle;
        end
      end
      default: state_d = Idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Idle;
    end else if (flush_i) begin
      state_q <= Idle;
    end else begin
      state_q <= state_d;
    end
  end

  // New walk, VPN captured
  assign issue_o         = (state_q == Idle) && req_valid_i;
  assign load_level_o    = (state_q == Lookup);
  assign mem_req_valid_o = (state_q == Send);
  assign mem_ans_rdy_o   = (state_q == Wait);
  assign step_o          = (state_q == Check) && !done_i;
  assign finish_o        = (state_q == Check) && done_i;
  // Request released once the answer slice drains
  assign req_rdy_o       = (state_q == Answer) && ans_rdy_i;

endmodule

// ==== src/mmu_cache.sv ====
/*
 * MMU cache for partial translations
 * Partial side keyed by VPN part 2, full side by parts 2 and 1,
 * FIFO replacement per side, flush drops all entries
 */

`include "mmu_settings.svh"

module mmu_cache (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             flush_i,
  input  logic [1:0][`VPN_PART_LEN-1:0]    tags_i,
  output mmu_bus_pkg::mmuc_lookup_t        lookup_o,
  input  mmu_bus_pkg::mmuc_write_t         write_i
);

  import mmu_bus_pkg::*;

  localparam int unsigned n_entries = `MMUC_ENTRIES;
  localparam int unsigned ptr_w     = (n_entries > 1) ? $clog2(n_entries) : 1;

  logic [n_entries-1:0]                            part_vld_q, full_vld_q;
  logic [n_entries-1:0][`VPN_PART_LEN-1:0]         part_tag_q;
  logic [n_entries-1:0][2*`VPN_PART_LEN-1:0]       full_tag_q;
  logic [n_entries-1:0][`PPN_LEN-1:0]              part_ppn_q, full_ppn_q;
  logic [ptr_w-1:0]                                part_ptr_q, full_ptr_q;

  // Full side scanned last so it wins
  always_comb begin
    lookup_o = '0;
    for (int i = 0; i < n_entries; i++) begin
      if (part_vld_q[i] && part_tag_q[i] == tags_i[1]) begin
        lookup_o.hit = 1'b1;
        lookup_o.ppn = part_ppn_q[i];
      end
    end
    for (int i = 0; i < n_entries; i++) begin
      if (full_vld_q[i] && full_tag_q[i] == tags_i) begin
        lookup_o.hit      = 1'b1;
        lookup_o.full_hit = 1'b1;
        lookup_o.ppn      = full_ppn_q[i];
      end
    end
  end

  // Valid bits and write pointers
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      part_vld_q <= '0;
      full_vld_q <= '0;
      part_ptr_q <= '0;
      full_ptr_q <= '0;
    end else if (flush_i) begin
      part_vld_q <= '0;
      full_vld_q <= '0;
      part_ptr_q <= '0;
      full_ptr_q <= '0;
    end else if (write_i.wr_en && write_i.full) begin
      full_vld_q[full_ptr_q] <= 1'b1;
      full_ptr_q <= (full_ptr_q == ptr_w'(n_entries - 1)) ? '0 : full_ptr_q + 1'b1;
    end else if (write_i.wr_en) begin
      part_vld_q[part_ptr_q] <= 1'b1;
      part_ptr_q <= (part_ptr_q == ptr_w'(n_entries - 1)) ? '0 : part_ptr_q + 1'b1;
    end
  end

  // Tags and PPNs of the slot under the pointer
  always_ff @(posedge clk_i) begin
    if (write_i.wr_en && write_i.full) begin
      full_tag_q[full_ptr_q] <= write_i.tag;
      full_ppn_q[full_ptr_q] <= write_i.ppn;
    end else if (write_i.wr_en) begin
      part_tag_q[part_ptr_q] <= write_i.tag[2*`VPN_PART_LEN-1 -: `VPN_PART_LEN];
      part_ppn_q[part_ptr_q] <= write_i.ppn;
    end
  end

endmodule

// ==== src/ptw.sv ====
/*
 * Page table walker datapath
 * VPN and level registers, PTE address maker, cache fill
 * and answer assembly around the control unit and checker
 */

`include "mmu_settings.svh"

module ptw (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          flush_i,
  input  mmu_bus_pkg::tlb_req_t         req_i,
  output logic                          req_rdy_o,
  output mmu_bus_pkg::tlb_ans_t         ans_o,
  input  logic                          ans_rdy_i,
  output mmu_bus_pkg::mem_req_t         mem_req_o,
  input  logic                          mem_req_rdy_i,
  input  mmu_bus_pkg::mem_ans_t         mem_ans_i,
  output logic                          mem_ans_rdy_o,
  input  logic [`PPN_LEN-1:0]           csr_root_ppn_i,
  output logic [1:0][`VPN_PART_LEN-1:0] mmuc_tags_o,
  input  mmu_bus_pkg::mmuc_lookup_t     mmuc_lookup_i,
  output mmu_bus_pkg::mmuc_write_t      mmuc_write_o
);

  import mmu_types_pkg::*;
  import mmu_bus_pkg::*;

  localparam int unsigned idx_pad = `PAGE_OFFSET_LEN - `VPN_PART_LEN;

  logic                  issue, load_level, step, mem_ans_hs;
  logic                  leaf, done_d, done_q;
  exception_e            exc_d, exc_q;
  vpn_t                  vpn_q;
  pte_t                  pte_q;
  pte_level_e            level_q, start_level, next_level;
  logic [`PPN_LEN-1:0]   start_ppn;
  logic [`PADDR_LEN-1:0] addr_d, addr_q;

  ptw_cu i_ptw_cu (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .flush_i         (flush_i),
    .req_valid_i     (req_i.valid),
    .mem_req_rdy_i   (mem_req_rdy_i),
    .mem_ans_valid_i (mem_ans_i.valid),
    .done_i          (done_q),
    .ans_rdy_i       (ans_rdy_i),
    .req_rdy_o       (req_rdy_o),
    .load_level_o    (load_level),
    .issue_o         (issue),
    .mem_req_valid_o (mem_req_o.valid),
    .mem_ans_rdy_o   (mem_ans_rdy_o),
    .step_o          (step),
    .finish_o        (ans_o.valid)
  );

  // Checks the incoming PTE, result registered with it
  pte_checker i_pte_checker (
    .level_i     (level_q),
    .pte_i       (mem_ans_i.pte),
    .mem_err_i   (mem_ans_i.err),
    .exception_o (exc_d),
    .leaf_o      (leaf),
    .done_o      (done_d)
  );

  assign mem_ans_hs  = mem_ans_i.valid && mem_ans_rdy_o;
  assign mmuc_tags_o = vpn_q[2:1];

  // Start point: full hit, partial hit or root table
  always_comb begin
    start_level = Lvl2;
    start_ppn   = csr_root_ppn_i;
    if (mmuc_lookup_i.full_hit) begin
      start_level = Lvl0;
      start_ppn   = mmuc_lookup_i.ppn;
    end else if (mmuc_lookup_i.hit) begin
      start_level = Lvl1;
      start_ppn   = mmuc_lookup_i.ppn;
    end
  end

  assign next_level = (level_q == Lvl2) ? Lvl1 : Lvl0;

  // Table base plus VPN part times 8
  assign addr_d = load_level ? {start_ppn, vpn_q[start_level], {idx_pad{1'b0}}}
                             : {pte_q.ppn, vpn_q[next_level], {idx_pad{1'b0}}};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      level_q <= Lvl2;
      done_q  <= 1'b0;
    end else begin
      if (load_level) begin
        level_q <= start_level;
      end else if (step) begin
        level_q <= next_level;
      end
      if (mem_ans_hs) begin
        done_q <= done_d;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue) begin
      vpn_q <= req_i.vpn;
    end
    if (load_level || step) begin
      addr_q <= addr_d;
    end
    if (mem_ans_hs) begin
      pte_q <= mem_ans_i.pte;
      exc_q <= exc_d;
    end
  end

  assign mem_req_o.pte_paddr = addr_q;

  // Fill on an accepted pointer, full entry below the root
  assign mmuc_write_o.wr_en = mem_ans_hs && !leaf && (exc_d == NoException);
  assign mmuc_write_o.full  = (level_q == Lvl1);
  assign mmuc_write_o.tag   = {vpn_q[2], (level_q == Lvl1) ? vpn_q[1] : {`VPN_PART_LEN{1'b0}}};
  assign mmuc_write_o.ppn   = mem_ans_i.pte.ppn;

  // Answer fields, PPN zeroed on a fault
  assign ans_o.ppn       = (exc_q == NoException) ? pte_q.ppn : '0;
  assign ans_o.page_type = (level_q == Lvl2) ? GibiPage :
                           (level_q == Lvl1) ? MebiPage : KibiPage;
  assign ans_o.exception = exc_q;
  assign ans_o.wrx       = '{w: pte_q.w, r: pte_q.r, x: pte_q.x};
  assign ans_o.d         = pte_q.d;
  assign ans_o.g         = pte_q.g;
  assign ans_o.u         = pte_q.u;

endmodule

// ==== src/mmu_walk_top.sv ====
/*
 * Sv39 walk subsystem top
 * Request slice, walker, MMU cache and answer slice
 */

`include "mmu_settings.svh"

module mmu_walk_top (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  flush_i,
  input  mmu_bus_pkg::tlb_req_t tlb_req_i,
  output logic                  tlb_req_rdy_o,
  output mmu_bus_pkg::tlb_ans_t tlb_ans_o,
  input  logic                  tlb_ans_rdy_i,
  output mmu_bus_pkg::mem_req_t mem_req_o,
  input  logic                  mem_req_rdy_i,
  input  mmu_bus_pkg::mem_ans_t mem_ans_i,
  output logic                  mem_ans_rdy_o,
  input  logic [`PPN_LEN-1:0]   csr_root_ppn_i
);

  import mmu_types_pkg::*;
  import mmu_bus_pkg::*;

  logic                          req_vld, req_rdy, ans_rdy, ans_vld;
  vpn_t                          req_vpn;
  tlb_req_t                      ptw_req;
  tlb_ans_t                      ptw_ans, ans_q;
  logic [1:0][`VPN_PART_LEN-1:0] mmuc_tags;
  mmuc_lookup_t                  mmuc_lookup;
  mmuc_write_t                   mmuc_write;

  stream_reg #(.payload_t(vpn_t)) i_req_reg (
    .clk_i, .rst_ni, .flush_i,
    .valid_i (tlb_req_i.valid),
    .ready_o (tlb_req_rdy_o),
    .data_i  (tlb_req_i.vpn),
    .valid_o (req_vld),
    .ready_i (req_rdy),
    .data_o  (req_vpn)
  );

  assign ptw_req = '{valid: req_vld, vpn: req_vpn};

  ptw i_ptw (
    .clk_i, .rst_ni, .flush_i, .mem_req_o, .mem_req_rdy_i, .mem_ans_i, .mem_ans_rdy_o,
    .csr_root_ppn_i,
    .req_i         (ptw_req),
    .req_rdy_o     (req_rdy),
    .ans_o         (ptw_ans),
    .ans_rdy_i     (ans_rdy),
    .mmuc_tags_o   (mmuc_tags),
    .mmuc_lookup_i (mmuc_lookup),
    .mmuc_write_o  (mmuc_write)
  );

  mmu_cache i_mmu_cache (
    .clk_i, .rst_ni, .flush_i,
    .tags_i   (mmuc_tags),
    .lookup_o (mmuc_lookup),
    .write_i  (mmuc_write)
  );

  stream_reg #(.payload_t(tlb_ans_t)) i_ans_reg (
    .clk_i, .rst_ni, .flush_i,
    .valid_i (ptw_ans.valid),
    .ready_o (ans_rdy),
    .data_i  (ptw_ans),
    .valid_o (ans_vld),
    .ready_i (tlb_ans_rdy_i),
    .data_o  (ans_q)
  );

  // Slice valid replaces the stored one
  assign tlb_ans_o = {ans_vld, ans_q[$bits(tlb_ans_t)-2:0]};

endmodule

// ==== tests/mmu_walk_properties.sv ====
/*
 * Walker handshake properties
 * Payload stability, idle outputs in reset, one memory read in flight
 */

module mmu_walk_properties (
  input logic                  clk_i,
  input logic                  rst_ni,
  input logic                  flush_i,
  input mmu_bus_pkg::tlb_ans_t ans_i,
  input logic                  ans_rdy_i,
  input mmu_bus_pkg::mem_req_t mem_req_i,
  input logic                  mem_req_rdy_i,
  input mmu_bus_pkg::mem_ans_t mem_ans_i,
  input logic                  mem_ans_rdy_i
);

  timeunit 1ns;
  timeprecision 100ps;

  // Failed assertion count, read by the testbench at the end
  int unsigned fails = 0;
  logic        pending_q;

  // Memory read between request and answer handshake
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= 1'b0;
    end else if (mem_req_i.valid && mem_req_rdy_i) begin
      pending_q <= 1'b1;
    end else if (mem_ans_i.valid && mem_ans_rdy_i) begin
      pending_q <= 1'b0;
    end
  end

  // Stalled payloads hold still
  assert property (@(posedge clk_i) disable iff (!rst_ni || flush_i)
    mem_req_i.valid && !mem_req_rdy_i |=> mem_req_i.valid && $stable(mem_req_i.pte_paddr))
  else begin
    fails++;
    $error("memory request changed before its handshake");
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni || flush_i)
    ans_i.valid && !ans_rdy_i |=> ans_i.valid && $stable(ans_i))
  else begin
    fails++;
    $error("TLB answer changed before its handshake");
  end

  // Nothing leaves the walker in reset
  assert property (@(posedge clk_i)
    !rst_ni |-> !ans_i.valid && !mem_req_i.valid && !mem_ans_rdy_i)
  else begin
    fails++;
    $error("walker output active during reset");
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni || flush_i)
    pending_q |-> !mem_req_i.valid)
  else begin
    fails++;
    $error("second memory request while one is outstanding");
  end

endmodule

bind mmu_walk_top mmu_walk_properties i_walk_props (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .flush_i       (flush_i),
  .ans_i         (tlb_ans_o),
  .ans_rdy_i     (tlb_ans_rdy_i),
  .mem_req_i     (mem_req_o),
  .mem_req_rdy_i (mem_req_rdy_i),
  .mem_ans_i     (mem_ans_i),
  .mem_ans_rdy_i (mem_ans_rdy_o)
);

// ==== tests/tb_mmu_walk.sv ====
/*
 * Sv39 walker testbench
 * Page table memory with random latency, directed walks checked
 * against a reference walk over the same table contents
 */

`include "mmu_settings.svh"

module tb_mmu_walk;

  timeunit 1ns;
  timeprecision 100ps;

  import mmu_types_pkg::*;
  import mmu_bus_pkg::*;

  typedef logic [`PADDR_LEN-1:0] paddr_t;
  typedef logic [`PPN_LEN-1:0]   ppn_t;

  localparam int unsigned walk_cycles = 60;
  localparam int unsigned max_walks   = 30;
  // Walk budget plus room for reset, flushes and held answers
  localparam int unsigned cycle_limit = max_walks * walk_cycles + 1200;
  localparam ppn_t        root_ppn    = 44'h1000;

  // Flag bytes, d a g u x w r v from the top
  localparam logic [7:0] ptr_flags   = 8'h01;
  localparam logic [7:0] leaf_flags  = 8'hD7;
  localparam logic [7:0] super_flags = 8'h6B;

  logic     clk_i;
  logic     rst_ni;
  logic     flush_i;
  tlb_req_t tlb_req_i;
  logic     tlb_req_rdy_o;
  tlb_ans_t tlb_ans_o;
  logic     tlb_ans_rdy_i;
  mem_req_t mem_req_o;
  logic     mem_req_rdy_i;
  mem_ans_t mem_ans_i;
  logic     mem_ans_rdy_o;
  ppn_t     csr_root_ppn_i;

  // Page table memory and addresses that answer with an error
  pte_t        pt_mem[paddr_t];
  bit          err_addr[paddr_t];
  paddr_t      seen_addr[8];
  int unsigned n_reads;

  // Reference walk result
  paddr_t      exp_addr[3];
  int unsigned exp_n;
  tlb_ans_t    exp_ans;

  logic [31:0] rng_state = 32'd18;
  int unsigned errors    = 0;
  int unsigned tests_run = 0;
  int unsigned walks     = 0;
  int unsigned cycles    = 0;

  mmu_walk_top DUT (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .flush_i        (flush_i),
    .tlb_req_i      (tlb_req_i),
    .tlb_req_rdy_o  (tlb_req_rdy_o),
    .tlb_ans_o      (tlb_ans_o),
    .tlb_ans_rdy_i  (tlb_ans_rdy_i),
    .mem_req_o      (mem_req_o),
    .mem_req_rdy_i  (mem_req_rdy_i),
    .mem_ans_i      (mem_ans_i),
    .mem_ans_rdy_o  (mem_ans_rdy_o),
    .csr_root_ppn_i (csr_root_ppn_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("Timeout after %0d cycles, the tests did not complete", cycles);
      $display("Testbench failed");
      $finish;
    end
  end

  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // Table base in pages, eight bytes per entry
  function automatic paddr_t pte_address(input ppn_t table_ppn, input int unsigned part);
    return paddr_t'(table_ppn) * 4096 + paddr_t'(part) * 8;
  endfunction

  function automatic vpn_t make_vpn(input int unsigned p2, input int unsigned p1,
                                    input int unsigned p0);
    vpn_t v;
    v[2] = p2[8:0];
    v[1] = p1[8:0];
    v[0] = p0[8:0];
    return v;
  endfunction

  task automatic map_pte(input ppn_t table_ppn, input int unsigned part, input ppn_t ppn,
                         input logic [7:0] flags);
    pte_t pte;
    pte = '0;
    pte.ppn = ppn;
    {pte.d, pte.a, pte.g, pte.u, pte.x, pte.w, pte.r, pte.v} = flags;
    pt_mem[pte_address(table_ppn, part)] = pte;
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    $display("[ERROR] %0t %s: got %0h expected %0h", $time, name, got, exp);
    errors++;
  endtask

  task automatic end_test(input string name, input int unsigned err_start);
    tests_run++;
    $display("%-16s finished with %0d errors", name, errors - err_start);
  endtask

  // Serves one read at a time, ready and answer each 0 to 3 cycles late
  initial begin : memory_model
    paddr_t      addr;
    int unsigned gap;
    pte_t        pte;
    logic        bad;
    wait (rst_ni);
    forever begin
      @(negedge clk_i);
      if (mem_req_o.valid) begin
        gap = next_random() % 4;
        repeat (gap) @(negedge clk_i);
        addr = mem_req_o.pte_paddr;
        mem_req_rdy_i = 1'b1;
        @(negedge clk_i);
        mem_req_rdy_i = 1'b0;
        if (n_reads < 8) begin
          seen_addr[n_reads] = addr;
        end
        n_reads++;
        pte = pt_mem.exists(addr) ? pt_mem[addr] : '0;
        bad = err_addr.exists(addr);
        gap = next_random() % 4;
        repeat (gap) @(negedge clk_i);
        mem_ans_i = '{valid: 1'b1, pte: pte, err: bad};
        while (!mem_ans_rdy_o) @(negedge clk_i);
        @(negedge clk_i);
        mem_ans_i = '0;
      end
    end
  end

  // Reference walk from the root over the table memory
  task automatic predict_walk(input vpn_t vpn);
    ppn_t   table_ppn;
    paddr_t addr;
    pte_t   pte;
    bit     done;
    int     lvl;
    exp_ans = '0;
    exp_ans.valid = 1'b1;
    exp_n = 0;
    table_ppn = root_ppn;
    done = 1'b0;
    for (lvl = 2; lvl >= 0 && !done; lvl--) begin
      addr = pte_address(table_ppn, vpn[lvl]);
      exp_addr[exp_n] = addr;
      exp_n++;
      pte = pt_mem.exists(addr) ? pt_mem[addr] : '0;
      done = 1'b1;
      exp_ans.page_type = (lvl == 2) ? GibiPage : (lvl == 1) ? MebiPage : KibiPage;
      if (err_addr.exists(addr)) begin
        exp_ans.exception = AccessFault;
      end else if (!pte.v || (pte.w && !pte.r)) begin
        exp_ans.exception = PageFault;
      end else if (pte.r || pte.x) begin
        // Superpage PPN must be a multiple of its page size in 4 KiB pages
        if (!pte.a || (lvl == 2 && pte.ppn % 44'h4_0000 != 0) ||
            (lvl == 1 && pte.ppn % 44'h200 != 0)) begin
          exp_ans.exception = PageFault;
        end else begin
          exp_ans.exception = NoException;
          exp_ans.ppn = pte.ppn;
          exp_ans.wrx = '{w: pte.w, r: pte.r, x: pte.x};
          exp_ans.d = pte.d;
          exp_ans.g = pte.g;
          exp_ans.u = pte.u;
        end
      end else if (lvl == 0) begin
        exp_ans.exception = PageFault;
      end else begin
        table_ppn = pte.ppn;
        done = 1'b0;
      end
    end
  endtask

  task automatic send_request(input vpn_t vpn);
    int unsigned waited;
    n_reads = 0;
    waited = 0;
    tlb_req_i = '{valid: 1'b1, vpn: vpn};
    while (!tlb_req_rdy_o && waited < walk_cycles) begin
      @(negedge clk_i);
      waited++;
    end
    if (!tlb_req_rdy_o) begin
      $display("Request for VPN %h was not accepted within %0d cycles", vpn, walk_cycles);
      errors++;
    end
    @(negedge clk_i);
    tlb_req_i = '0;
  endtask

  task automatic wait_answer(output tlb_ans_t ans, output bit seen);
    int unsigned waited;
    waited = 0;
    while (!tlb_ans_o.valid && waited < walk_cycles) begin
      @(negedge clk_i);
      waited++;
    end
    seen = tlb_ans_o.valid;
    ans = tlb_ans_o;
    if (!seen) begin
      $display("No answer arrived within %0d cycles of the request", walk_cycles);
      errors++;
    end
  endtask

  // want_reads below zero expects the full path, zero skips the count
  task automatic check_walk(input vpn_t vpn, input int want_reads, input exception_e want_exc);
    tlb_ans_t    ans;
    bit          seen;
    int unsigned want;
    int unsigned i;
    predict_walk(vpn);
    walks++;
    send_request(vpn);
    wait_answer(ans, seen);
    @(negedge clk_i);
    if (seen) begin
      if (ans.exception !== want_exc) begin
        report_mismatch("tlb_ans_o.exception", ans.exception, want_exc);
      end
      if (want_exc == NoException) begin
        if (ans.ppn !== exp_ans.ppn) begin
          report_mismatch("tlb_ans_o.ppn", ans.ppn, exp_ans.ppn);
        end
        if (ans.page_type !== exp_ans.page_type) begin
          report_mismatch("tlb_ans_o.page_type", ans.page_type, exp_ans.page_type);
        end
        if ({ans.wrx, ans.d, ans.g, ans.u} !==
            {exp_ans.wrx, exp_ans.d, exp_ans.g, exp_ans.u}) begin
          report_mismatch("tlb_ans_o.wrx_d_g_u", {ans.wrx, ans.d, ans.g, ans.u},
                          {exp_ans.wrx, exp_ans.d, exp_ans.g, exp_ans.u});
        end
      end
      want = (want_reads < 0) ? exp_n : want_reads;
      if (want_reads != 0 && n_reads != want) begin
        report_mismatch("memory reads", n_reads, want);
      end
      // Cached walks read the tail of the full path
      if (n_reads > exp_n) begin
        $display("Walk made %0d reads but the table path has only %0d", n_reads, exp_n);
        errors++;
      end else begin
        for (i = 0; i < n_reads; i++) begin
          if (seen_addr[i] !== exp_addr[exp_n - n_reads + i]) begin
            report_mismatch("mem_req_o.pte_paddr", seen_addr[i],
                            exp_addr[exp_n - n_reads + i]);
          end
        end
      end
    end
  endtask

  task automatic flush_cache();
    flush_i = 1'b1;
    @(negedge clk_i);
    flush_i = 1'b0;
    @(negedge clk_i);
  endtask

  // Checked while reset is held, then right after release
  task automatic reset_state_test();
    int unsigned e0;
    int unsigned phase;
    e0 = errors;
    for (phase = 0; phase < 2; phase++) begin
      if (tlb_ans_o.valid !== 1'b0) begin
        report_mismatch("tlb_ans_o.valid", tlb_ans_o.valid, 1'b0);
      end
      if (mem_req_o.valid !== 1'b0) begin
        report_mismatch("mem_req_o.valid", mem_req_o.valid, 1'b0);
      end
      if (tlb_req_rdy_o !== 1'b1) begin
        report_mismatch("tlb_req_rdy_o", tlb_req_rdy_o, 1'b1);
      end
      if (mem_ans_rdy_o !== 1'b0) begin
        report_mismatch("mem_ans_rdy_o", mem_ans_rdy_o, 1'b0);
      end
      rst_ni = 1'b1;
      @(negedge clk_i);
    end
    end_test("reset state", e0);
  endtask

  task automatic cold_walk_test();
    int unsigned e0;
    e0 = errors;
    map_pte(root_ppn, 1, 44'h2000, ptr_flags);
    map_pte(44'h2000, 2, 44'h2001, ptr_flags);
    map_pte(44'h2001, 3, 44'hA_BCDE, leaf_flags);
    flush_cache();
    check_walk(make_vpn(1, 2, 3), -1, NoException);
    end_test("cold 4k walk", e0);
  endtask

  task automatic cache_reuse_test();
    int unsigned e0;
    e0 = errors;
    map_pte(root_ppn, 5, 44'h3000, ptr_flags);
    map_pte(44'h3000, 6, 44'h3001, ptr_flags);
    map_pte(44'h3001, 7, 44'h111, leaf_flags);
    map_pte(44'h3001, 8, 44'h222, super_flags);
    map_pte(44'h3000, 9, 44'h3002, ptr_flags);
    map_pte(44'h3002, 10, 44'h333, leaf_flags);
    flush_cache();
    check_walk(make_vpn(5, 6, 7), 3, NoException);
    check_walk(make_vpn(5, 6, 7), 1, NoException);
    check_walk(make_vpn(5, 6, 8), 1, NoException);
    check_walk(make_vpn(5, 9, 10), 2, NoException);
    flush_cache();
    check_walk(make_vpn(5, 6, 7), 3, NoException);
    end_test("mmu cache reuse", e0);
  endtask

  task automatic superpage_test();
    int unsigned e0;
    e0 = errors;
    map_pte(root_ppn, 20, 44'h4_0000, super_flags);
    map_pte(root_ppn, 21, 44'h4000, ptr_flags);
    map_pte(44'h4000, 1, 44'h5200, super_flags);
    map_pte(root_ppn, 22, 44'h4100, ptr_flags);
    map_pte(44'h4100, 2, 44'h5201, super_flags);
    map_pte(root_ppn, 23, 44'h4_0200, super_flags);
    flush_cache();
    check_walk(make_vpn(20, 4, 5), -1, NoException);
    check_walk(make_vpn(21, 1, 9), -1, NoException);
    check_walk(make_vpn(22, 2, 0), -1, PageFault);
    check_walk(make_vpn(23, 0, 0), -1, PageFault);
    end_test("superpages", e0);
  endtask

  task automatic fault_test();
    int unsigned e0;
    e0 = errors;
    // Invalid leaf, then write without read, both otherwise well formed
    map_pte(root_ppn, 30, 44'h8_0000, 8'hD6);
    map_pte(root_ppn, 31, 44'h7001, 8'h45);
    // Aligned leaf with the accessed bit cleared
    map_pte(root_ppn, 32, 44'h4200, ptr_flags);
    map_pte(44'h4200, 3, 44'h7200, 8'h93);
    // Pointer found in the last level
    map_pte(root_ppn, 33, 44'h4300, ptr_flags);
    map_pte(44'h4300, 4, 44'h4301, ptr_flags);
    map_pte(44'h4301, 5, 44'h4302, ptr_flags);
    map_pte(root_ppn, 34, 44'h4400, ptr_flags);
    map_pte(44'h4400, 6, 44'h7003, leaf_flags);
    err_addr[pte_address(44'h4400, 6)] = 1'b1;
    flush_cache();
    check_walk(make_vpn(30, 0, 0), -1, PageFault);
    check_walk(make_vpn(31, 0, 0), -1, PageFault);
    check_walk(make_vpn(32, 3, 0), -1, PageFault);
    check_walk(make_vpn(33, 4, 5), -1, PageFault);
    check_walk(make_vpn(34, 6, 1), -1, AccessFault);
    end_test("faults", e0);
  endtask

  task automatic backpressure_test();
    int unsigned e0;
    int unsigned k;
    tlb_ans_t    held;
    bit          seen;
    vpn_t        vpn;
    e0 = errors;
    flush_cache();
    vpn = make_vpn(1, 2, 3);
    predict_walk(vpn);
    walks++;
    tlb_ans_rdy_i = 1'b0;
    send_request(vpn);
    wait_answer(held, seen);
    if (seen) begin
      if (held.exception !== exp_ans.exception) begin
        report_mismatch("tlb_ans_o.exception", held.exception, exp_ans.exception);
      end
      if (held.ppn !== exp_ans.ppn) begin
        report_mismatch("tlb_ans_o.ppn", held.ppn, exp_ans.ppn);
      end
      // Stalled answer must stay put and block new requests
      for (k = 0; k < 6; k++) begin
        @(negedge clk_i);
        if (tlb_ans_o !== held) begin
          report_mismatch("tlb_ans_o", tlb_ans_o, held);
        end
        if (tlb_req_rdy_o !== 1'b0) begin
          report_mismatch("tlb_req_rdy_o", tlb_req_rdy_o, 1'b0);
        end
      end
    end
    tlb_ans_rdy_i = 1'b1;
    @(negedge clk_i);
    if (tlb_ans_o.valid !== 1'b0) begin
      report_mismatch("tlb_ans_o.valid", tlb_ans_o.valid, 1'b0);
    end
    // Mixed hits and misses under random memory gaps
    for (k = 0; k < 8; k++) begin
      vpn = make_vpn(5, (next_random() % 2 != 0) ? 6 : 9, 4 + next_random() % 8);
      predict_walk(vpn);
      check_walk(vpn, 0, exp_ans.exception);
    end
    end_test("back-pressure", e0);
  endtask

  initial begin : main
    rst_ni = 1'b0;
    flush_i = 1'b0;
    tlb_req_i = '0;
    tlb_ans_rdy_i = 1'b1;
    mem_req_rdy_i = 1'b0;
    mem_ans_i = '0;
    csr_root_ppn_i = root_ppn;
    n_reads = 0;
    repeat (8) @(negedge clk_i);
    reset_state_test();
    cold_walk_test();
    cache_reuse_test();
    superpage_test();
    fault_test();
    backpressure_test();
    if (DUT.i_walk_props.fails != 0) begin
      $display("Bound assertions failed %0d times", DUT.i_walk_props.fails);
      errors += DUT.i_walk_props.fails;
    end
    $display("%0d tests, %0d walks, %0d errors", tests_run, walks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+src
src/mmu_types_pkg.sv
src/mmu_bus_pkg.sv
src/stream_reg.sv
src/pte_checker.sv
src/ptw_cu.sv
src/mmu_cache.sv
src/ptw.sv
src/mmu_walk_top.sv
tests/mmu_walk_properties.sv
tests/tb_mmu_walk.sv
